// File: design/io_cmd_pkg.sv
//################################################
// io command package: SPI command codes, frame
// counters and the core identity byte
//################################################

package io_cmd_pkg;

	// one byte on the SPI bus
	typedef logic [7:0] cmd_t;

	// commands understood by the IO bridge
	typedef enum cmd_t {
		CMD_BUT_SW   = 8'h01,
		CMD_JOY0     = 8'h02,
		CMD_JOY1     = 8'h03,
		CMD_KBD      = 8'h05,
		CMD_CONF_STR = 8'h14,
		CMD_STATUS   = 8'h15
	} cmd_code_e;

	// bit position inside a byte, msb first on the wire
	typedef logic [2:0] bit_cnt_t;

	// byte index inside a transaction, sticks at 63
	typedef logic [5:0] byte_cnt_t;

	// transaction position as seen by the reply side
	typedef struct packed {
		cmd_t      cmd;
		byte_cnt_t byte_cnt;
		bit_cnt_t  bit_cnt;
	} spi_frame_t;

	// 8 bit core type, first byte of every reply
	localparam cmd_t CORE_TYPE = 8'hA4;

endpackage

// File: design/io_input_pkg.sv
//################################################
// io input package: joystick, panel, status and
// keyboard byte types
//################################################

package io_input_pkg;

	// direction and fire lines, one bit each
	typedef logic [5:0] joystick_t;

	// board switches and buttons
	// buttons sit in the low bits of the SPI byte
	typedef struct packed {
		logic [1:0] switches;
		logic [1:0] buttons;
	} panel_t;

	// core status word written by the IO controller
	typedef logic [7:0] status_t;

	// one PS/2 scan code byte
	typedef logic [7:0] kbd_byte_t;

endpackage

// File: design/spi_cmd_rx.sv
//################################################
// SPI command receiver: shifts MOSI, tracks bit and
// byte position, updates registers and key writes
//################################################

`timescale 1ns/10ps

module spi_cmd_rx (
	input  logic                    SPI_CLK,
	input  logic                    SPI_SS_IO,
	input  logic                    spi_mosi,
	output io_cmd_pkg::spi_frame_t  frame,
	output io_input_pkg::joystick_t joy0,
	output io_input_pkg::joystick_t joy1,
	output io_input_pkg::panel_t    panel,
	output io_input_pkg::status_t   status,
	output logic                    kbd_wr_valid,
	output io_input_pkg::kbd_byte_t kbd_wr_data
);

	import io_cmd_pkg::*;

	// first seven bits of the byte in flight
	logic [6:0] sbuf;
	// full byte, completed by the bit on the line right now
	logic [7:0] rx_byte;
	cmd_t       cmd;
	bit_cnt_t   bit_cnt;
	byte_cnt_t  byte_cnt;
	// eighth bit of a byte is being sampled in this edge
	logic       byte_done;
	// completed byte belongs to the payload
	logic       payload_done;

	assign rx_byte      = {sbuf, spi_mosi};
	assign byte_done    = (bit_cnt == 3'd7);
	assign payload_done = byte_done && (byte_cnt != '0);

	// shift register, no reset, framing comes from bit_cnt
	always_ff @(posedge SPI_CLK) begin
		sbuf <= rx_byte[6:0];
	end

	// position counters and command latch
	// deselect drops any partial byte
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt  <= '0;
			byte_cnt <= '0;
			cmd      <= '0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (byte_done) begin
				// saturate so long reads stay past the string
				if (byte_cnt != '1)
					byte_cnt <= byte_cnt + 6'd1;
				// byte 0 is the command
				if (byte_cnt == '0)
					cmd <= rx_byte;
			end
		end
	end

	// target registers keep their value across deselect
	// each payload byte overwrites, last one wins
	always_ff @(posedge SPI_CLK) begin
		if (payload_done) begin
			case (cmd)
				CMD_BUT_SW: panel  <= rx_byte[3:0];
				CMD_JOY0:   joy0   <= rx_byte[5:0];
				CMD_JOY1:   joy1   <= rx_byte[5:0];
				CMD_STATUS: status <= rx_byte;
				default: ;
			endcase
		end
	end

	// key byte strobe, one SPI_CLK wide, taken by the fifo in this edge
	assign kbd_wr_valid = payload_done && (cmd == CMD_KBD);
	assign kbd_wr_data  = rx_byte;

	// position handed to the MISO side
	assign frame.cmd      = cmd;
	assign frame.byte_cnt = byte_cnt;
	assign frame.bit_cnt  = bit_cnt;

endmodule

// File: design/spi_reply_tx.sv
//################################################
// MISO driver: core type byte, then the config
// string under the string read command
//################################################

`timescale 1ns/10ps

module spi_reply_tx #(
	parameter logic [127:0] CONF_STR = "ZX01;P;         "
) (
	input  logic                   SPI_CLK,
	input  logic                   SPI_SS_IO,
	input  io_cmd_pkg::spi_frame_t frame,
	output tri logic               spi_miso
);

	import io_cmd_pkg::*;

	// line enable, off while deselected
	logic       miso_oe;
	// bit currently presented on the line
	logic       miso_bit;
	// character of the string for this byte, 0 is the first one
	logic [3:0] char_idx;
	// bit of the 128 bit string, first char sits at the top
	logic [6:0] str_bit;
	// string still has characters left
	logic       in_string;

	assign char_idx  = 4'(frame.byte_cnt - 6'd1);
	assign str_bit   = {~char_idx, ~frame.bit_cnt};
	assign in_string = (frame.byte_cnt <= 6'd16);

	// enable follows select on falling edges
	always_ff @(negedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			miso_oe <= 1'b0;
		else
			miso_oe <= 1'b1;
	end

	// data changes on falling edges so the master samples it stable
	always_ff @(negedge SPI_CLK) begin
		if (frame.byte_cnt == '0) begin
			// msb first
			miso_bit <= CORE_TYPE[~frame.bit_cnt];
		end else if (frame.cmd == CMD_CONF_STR) begin
			// zeros once the string is exhausted
			if (in_string)
				miso_bit <= CONF_STR[str_bit];
			else
				miso_bit <= 1'b0;
		end
		// other commands hold the last bit
	end

	assign spi_miso = miso_oe ? miso_bit : 1'bz;

endmodule

// File: design/ps2_fifo.sv
//################################################
// dual clock keyboard FIFO: SPI side writes,
// PS/2 side reads, Gray pointers cross domains
//################################################

`timescale 1ns/10ps

module ps2_fifo #(
	parameter int PS2_FIFO_BITS = 3
) (
	input  logic                    SPI_CLK,
	input  logic                    kbd_wr_valid,
	input  io_input_pkg::kbd_byte_t kbd_wr_data,
	input  logic                    clk,
	input  logic                    core_reset,
	output logic                    kbd_valid,
	output io_input_pkg::kbd_byte_t kbd_data,
	input  logic                    kbd_ready
);

	import io_input_pkg::*;

	localparam int DEPTH = 2 ** PS2_FIFO_BITS;

	// pointer with one wrap bit above the address
	typedef logic [PS2_FIFO_BITS:0] ptr_t;

	function automatic ptr_t bin2gray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

	kbd_byte_t mem [DEPTH];

	// write side, SPI_CLK domain
	ptr_t wr_bin;
	ptr_t wr_gray;
	ptr_t rd_gray_meta;
	ptr_t rd_gray_sync;
	logic wr_rst_meta;
	logic wr_rst;
	logic full;
	logic wr_en;

	// read side, clk domain
	ptr_t rd_bin;
	ptr_t rd_gray;
	ptr_t wr_gray_meta;
	ptr_t wr_gray_sync;
	logic rd_en;

	// core reset brought into the SPI domain
	always_ff @(posedge SPI_CLK) begin
		wr_rst_meta <= core_reset;
		wr_rst      <= wr_rst_meta;
	end

	// full when the top two gray bits differ and the rest match
	assign full  = (wr_gray == {~rd_gray_sync[PS2_FIFO_BITS:PS2_FIFO_BITS-1],
		rd_gray_sync[PS2_FIFO_BITS-2:0]});
	// no stall toward the bus master, a byte into a full fifo is lost
	assign wr_en = kbd_wr_valid && !full;

	always_ff @(posedge SPI_CLK) begin
		if (wr_rst) begin
			wr_bin       <= '0;
			wr_gray      <= '0;
			rd_gray_meta <= '0;
			rd_gray_sync <= '0;
		end else begin
			rd_gray_meta <= rd_gray;
			rd_gray_sync <= rd_gray_meta;
			if (wr_en) begin
				wr_bin  <= wr_bin + ptr_t'(1);
				wr_gray <= bin2gray(wr_bin + ptr_t'(1));
			end
		end
	end

	// storage, written only in the SPI domain
	always_ff @(posedge SPI_CLK) begin
		if (wr_en)
			mem[wr_bin[PS2_FIFO_BITS-1:0]] <= kbd_wr_data;
	end

	// oldest byte shown while the read side sees data
	assign kbd_valid = (rd_gray != wr_gray_sync);
	assign kbd_data  = mem[rd_bin[PS2_FIFO_BITS-1:0]];
	assign rd_en     = kbd_valid && kbd_ready;

	always_ff @(posedge clk) begin
		if (core_reset) begin
			rd_bin       <= '0;
			rd_gray      <= '0;
			wr_gray_meta <= '0;
			wr_gray_sync <= '0;
		end else begin
			wr_gray_meta <= wr_gray;
			wr_gray_sync <= wr_gray_meta;
			if (rd_en) begin
				rd_bin  <= rd_bin + ptr_t'(1);
				rd_gray <= bin2gray(rd_bin + ptr_t'(1));
			end
		end
	end

endmodule

// File: design/ps2_tx.sv
//################################################
// PS/2 device frame serializer, 11 bit frames with
// a PS/2 clock gated from clk
//################################################

`timescale 1ns/10ps

module ps2_tx (
	input  logic                    clk,
	input  logic                    core_reset,
	input  logic                    kbd_valid,
	input  io_input_pkg::kbd_byte_t kbd_data,
	output logic                    kbd_ready,
	output logic                    ps2_clk,
	output logic                    ps2_data
);

	import io_input_pkg::*;

	// state names the bit that is on the line
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_PARITY,
		ST_STOP
	} tx_state_e;

	tx_state_e  state;
	// remaining data bits, lsb goes out next
	kbd_byte_t  tx_byte;
	// odd parity, running xor seeded with 1
	logic       parity;
	// data bit on the line, 0 to 7
	logic [2:0] bit_idx;
	logic       accept;

	assign kbd_ready = (state == ST_IDLE);
	assign accept    = kbd_valid && kbd_ready;

	always_ff @(posedge clk) begin
		if (core_reset) begin
			state    <= ST_IDLE;
			ps2_data <= 1'b1;
			parity   <= 1'b1;
			bit_idx  <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						// start bit
						ps2_data <= 1'b0;
						parity   <= 1'b1;
						state    <= ST_START;
					end
				end
				ST_START: begin
					ps2_data <= tx_byte[0];
					parity   <= parity ^ tx_byte[0];
					bit_idx  <= '0;
					state    <= ST_DATA;
				end
				ST_DATA: begin
					if (bit_idx == 3'd7) begin
						ps2_data <= parity;
						state    <= ST_PARITY;
					end else begin
						ps2_data <= tx_byte[0];
						parity   <= parity ^ tx_byte[0];
						bit_idx  <= bit_idx + 3'd1;
					end
				end
				ST_PARITY: begin
					// stop bit
					ps2_data <= 1'b1;
					state    <= ST_STOP;
				end
				default: begin
					// stop bit done, next byte may come in the next cycle
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// data shifter, loaded on accept and shifted as bits leave
	always_ff @(posedge clk) begin
		if (accept)
			tx_byte <= kbd_data;
		else if (state == ST_START || state == ST_DATA)
			tx_byte <= tx_byte >> 1;
	end

	// clock runs only while a frame is on the line
	assign ps2_clk = clk | (state == ST_IDLE);

endmodule

// File: design/user_io.sv
//################################################
// IO bridge top: SPI command receiver, MISO reply,
// keyboard FIFO and PS/2 serializer
//################################################

`timescale 1ns/10ps

module user_io #(
	parameter int           PS2_FIFO_BITS = 3,
	parameter logic [127:0] CONF_STR      = "ZX01;P;         "
) (
	input  logic                    SPI_CLK,
	input  logic                    SPI_SS_IO,
	input  logic                    spi_mosi,
	output tri logic                spi_miso,
	input  logic                    clk,
	input  logic                    core_reset,
	output io_input_pkg::joystick_t joy0,
	output io_input_pkg::joystick_t joy1,
	output io_input_pkg::panel_t    panel,
	output io_input_pkg::status_t   status,
	output logic                    ps2_clk,
	output logic                    ps2_data
);

	import io_cmd_pkg::*;
	import io_input_pkg::*;

	// transaction position, receiver to reply side
	spi_frame_t frame;

	// key bytes into the fifo, SPI domain
	logic      kbd_wr_valid;
	kbd_byte_t kbd_wr_data;

	// fifo to serializer handshake, clk domain
	logic      kbd_valid;
	kbd_byte_t kbd_data;
	logic      kbd_ready;

	spi_cmd_rx spi_cmd_rx_i (
		.SPI_CLK      (SPI_CLK),
		.SPI_SS_IO    (SPI_SS_IO),
		.spi_mosi     (spi_mosi),
		.frame        (frame),
		.joy0         (joy0),
		.joy1         (joy1),
		.panel        (panel),
		.status       (status),
		.kbd_wr_valid (kbd_wr_valid),
		.kbd_wr_data  (kbd_wr_data)
	);

	spi_reply_tx #(
		.CONF_STR (CONF_STR)
	) spi_reply_tx_i (
		.SPI_CLK   (SPI_CLK),
		.SPI_SS_IO (SPI_SS_IO),
		.frame     (frame),
		.spi_miso  (spi_miso)
	);

	ps2_fifo #(
		.PS2_FIFO_BITS (PS2_FIFO_BITS)
	) ps2_fifo_i (
		.SPI_CLK      (SPI_CLK),
		.kbd_wr_valid (kbd_wr_valid),
		.kbd_wr_data  (kbd_wr_data),
		.clk          (clk),
		.core_reset   (core_reset),
		.kbd_valid    (kbd_valid),
		.kbd_data     (kbd_data),
		.kbd_ready    (kbd_ready)
	);

	ps2_tx ps2_tx_i (
		.clk        (clk),
		.core_reset (core_reset),
		.kbd_valid  (kbd_valid),
		.kbd_data   (kbd_data),
		.kbd_ready  (kbd_ready),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data)
	);

endmodule

// File: test/spi_host_tasks.svh
//################################################
// SPI master tasks: select, shift bits and bytes,
// open a command and release the slave
//################################################

`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// select on a rising edge, the first bit goes out in the same edge
task automatic select_slave();
	@(posedge SPI_CLK);
	SPI_SS_IO <= 1'b0;
endtask

// msb first, mosi set on one rising edge and sampled by the slave on the next
// miso was set on the falling edge before, so it is read on that same rising edge
// returns on the edge that sampled the last bit
task automatic shift_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
	rx = 8'h00;
	for (int i = 7; i > 7 - nbits; i--) begin
		spi_mosi <= tx[i];
		@(posedge SPI_CLK);
		rx[i] = spi_miso;
	end
endtask

task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
	shift_bits(tx, 8, rx);
endtask

// command byte out, core type must come back in the same byte
task automatic start_command(input logic [7:0] cmd);
	logic [7:0] rx;
	select_slave();
	shift_byte(cmd, rx);
	check_value("spi_miso byte 0", rx, CORE_TYPE_EXP);
endtask

// deselect right after the last sampled bit, then idle
// a floating miso reads 0 through the pull-down
// a line left driven would show the core type msb once the counters clear
task automatic release_slave(input int idle_cycles);
	SPI_SS_IO <= 1'b1;
	spi_mosi  <= 1'b0;
	repeat (idle_cycles) begin
		@(posedge SPI_CLK);
		check_value("spi_miso idle", {7'b0, spi_miso}, 8'h00);
	end
endtask

`endif

// File: test/tb_user_io.sv
//################################################
// testbench for the IO bridge: core type, config
// string, registers and PS/2 keyboard frames
//################################################

`timescale 1ns/10ps

module tb_user_io;

	import io_input_pkg::*;

	localparam int SPI_PERIOD = 4;
	localparam int CLK_PERIOD = 10;
	localparam logic [127:0] CONF_STR = "ZX01;P;         ";
	localparam logic [7:0] CORE_TYPE_EXP = 8'hA4;
	localparam logic [7:0] CMD_PANEL  = 8'h01;
	localparam logic [7:0] CMD_JOY0   = 8'h02;
	localparam logic [7:0] CMD_JOY1   = 8'h03;
	localparam logic [7:0] CMD_KBD    = 8'h05;
	localparam logic [7:0] CMD_CONF   = 8'h14;
	localparam logic [7:0] CMD_STATUS = 8'h15;
	localparam logic [7:0] REG_CMDS [4] = '{CMD_PANEL, CMD_JOY0, CMD_JOY1, CMD_STATUS};
	// fills the fifo exactly, nothing may be dropped
	localparam int N_KEYS = 8;
	// 11 bit frames plus one idle cycle each, and slack for the synchronizers
	localparam int KBD_WAIT = N_KEYS * 12 + 20;
	// run length estimate in ns: one byte, and select plus idle around a transaction
	localparam int BYTE_T = 8 * SPI_PERIOD;
	localparam int OVH_T = 3 * SPI_PERIOD;
	localparam int EST_T = 3 * CLK_PERIOD + 3 * SPI_PERIOD
		+ 6 * (BYTE_T + OVH_T)
		+ 21 * BYTE_T + OVH_T
		+ 12 * (5 * BYTE_T + OVH_T)
		+ (N_KEYS + 1) * BYTE_T + OVH_T + KBD_WAIT * CLK_PERIOD
		+ 4 * (4 * BYTE_T + 2 * OVH_T);

	logic SPI_CLK;
	logic SPI_SS_IO;
	logic spi_mosi;
	wire  spi_miso;
	logic clk;
	logic core_reset;
	joystick_t joy0;
	joystick_t joy1;
	panel_t    panel;
	status_t   status;
	logic ps2_clk;
	logic ps2_data;

	integer seed = 96060;
	int err_cnt = 0;
	int chk_cnt = 0;
	int test_cnt = 0;
	int test_err_base = 0;

	// register model, known marks what has been written so far
	logic [3:0] exp_panel;
	logic [5:0] exp_joy0;
	logic [5:0] exp_joy1;
	logic [7:0] exp_status;
	logic [3:0] known = 4'b0000;

	// keys sent and not yet seen as frames
	logic [7:0] key_q[$];
	// no PS/2 traffic expected
	logic kbd_quiet = 1'b1;

	// released line reads 0
	pulldown (spi_miso);

	user_io #(
		.PS2_FIFO_BITS (3),
		.CONF_STR      (CONF_STR)
	) user_io_i (
		.SPI_CLK    (SPI_CLK),
		.SPI_SS_IO  (SPI_SS_IO),
		.spi_mosi   (spi_mosi),
		.spi_miso   (spi_miso),
		.clk        (clk),
		.core_reset (core_reset),
		.joy0       (joy0),
		.joy1       (joy1),
		.panel      (panel),
		.status     (status),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data)
	);

	initial begin
		SPI_CLK = 1'b0;
		forever #(SPI_PERIOD / 2) SPI_CLK = ~SPI_CLK;
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		chk_cnt++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
			err_cnt++;
		end
	endtask

	`include "spi_host_tasks.svh"

	task automatic check_registers();
		if (known[0])
			check_value("panel", {4'b0, panel}, {4'b0, exp_panel});
		if (known[1])
			check_value("joy0", {2'b0, joy0}, {2'b0, exp_joy0});
		if (known[2])
			check_value("joy1", {2'b0, joy1}, {2'b0, exp_joy1});
		if (known[3])
			check_value("status", status, exp_status);
	endtask

	// nb random payload bytes, the target keeps the low bits of the last one
	task automatic write_register(input logic [7:0] cmd, input int nb);
		logic [7:0] b;
		logic [7:0] rx;
		b = 8'h00;
		start_command(cmd);
		for (int k = 0; k < nb; k++) begin
			b = 8'($random(seed));
			shift_byte(b, rx);
		end
		release_slave(2);
		case (cmd)
			CMD_PANEL: begin
				exp_panel = b[3:0];
				known[0] = 1'b1;
			end
			CMD_JOY0: begin
				exp_joy0 = b[5:0];
				known[1] = 1'b1;
			end
			CMD_JOY1: begin
				exp_joy1 = b[5:0];
				known[2] = 1'b1;
			end
			default: begin
				exp_status = b;
				known[3] = 1'b1;
			end
		endcase
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s finished, %0d errors", test_cnt + 1, name, err_cnt - test_err_base);
		test_err_base = err_cnt;
		test_cnt++;
	endtask

	// rebuild frames from the rising PS/2 clock edges
	// start, 8 data lsb first, odd parity, stop
	initial begin : ps2_monitor
		logic [10:0] bits;
		@(negedge core_reset);
		forever begin
			for (int i = 0; i < 11; i++) begin
				@(posedge ps2_clk);
				bits[i] = ps2_data;
			end
			check_value("ps2_data start", {7'b0, bits[0]}, 8'h00);
			check_value("ps2_data parity", {7'b0, ^bits[9:1]}, 8'h01);
			check_value("ps2_data stop", {7'b0, bits[10]}, 8'h01);
			if (key_q.size() == 0) begin
				$display("unexpected PS/2 frame carrying 0x%02h", bits[8:1]);
				err_cnt++;
			end else begin
				check_value("ps2 key", bits[8:1], key_q.pop_front());
			end
			// next frame cannot start before the low phase that follows the stop bit
			@(negedge clk);
			check_value("ps2_clk after frame", {7'b0, ps2_clk}, 8'h01);
		end
	end

	// ps2_clk must rest high with no keys in flight
	initial begin : ps2_idle_check
		@(negedge core_reset);
		forever begin
			@(negedge clk);
			if (kbd_quiet)
				check_value("ps2_clk idle", {7'b0, ps2_clk}, 8'h01);
		end
	end

	initial begin : watchdog
		#(2 * EST_T);
		$display("watchdog: run did not finish within %0d ns", 2 * EST_T);
		$display("Some tests failed");
		$fatal(1, "simulation stopped by the watchdog");
	end

	initial begin : main
		logic [7:0] rx;
		logic [7:0] exp_char;
		int wait_cyc;
		SPI_SS_IO  = 1'b1;
		spi_mosi   = 1'b0;
		core_reset = 1'b1;
		repeat (3) @(posedge clk);
		core_reset <= 1'b0;
		release_slave(3);

		// random command bytes, no payload
		for (int i = 0; i < 6; i++) begin
			start_command(8'($random(seed)));
			release_slave(2);
		end
		end_test("core type");

		start_command(CMD_CONF);
		for (int n = 1; n <= 20; n++) begin
			shift_byte(8'h00, rx);
			exp_char = (n <= 16) ? CONF_STR[(16 - n) * 8 +: 8] : 8'h00;
			check_value($sformatf("spi_miso byte %0d", n), rx, exp_char);
		end
		release_slave(2);
		end_test("config string");

		// first round fills the model, later rounds also see the others hold
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 4; c++) begin
				write_register(REG_CMDS[c], 2 + ({$random(seed)} % 3));
				check_registers();
			end
		end
		end_test("registers");

		kbd_quiet = 1'b0;
		start_command(CMD_KBD);
		for (int k = 0; k < N_KEYS; k++) begin
			exp_char = 8'($random(seed));
			key_q.push_back(exp_char);
			shift_byte(exp_char, rx);
		end
		release_slave(2);
		wait_cyc = 0;
		while (key_q.size() != 0 && wait_cyc < KBD_WAIT) begin
			@(posedge clk);
			wait_cyc++;
		end
		if (key_q.size() != 0) begin
			$display("keyboard: %0d bytes never came out as PS/2 frames", key_q.size());
			err_cnt++;
		end
		kbd_quiet = 1'b1;
		end_test("keyboard");

		// 5 bits then deselect, the next transaction must frame from its command
		for (int c = 0; c < 4; c++) begin
			start_command(REG_CMDS[c]);
			shift_bits(8'($random(seed)), 5, rx);
			release_slave(2);
			check_registers();
			write_register(REG_CMDS[c], 1);
			check_registers();
		end
		end_test("aborted byte");

		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: build.f
+incdir+test
design/io_cmd_pkg.sv
design/io_input_pkg.sv
design/spi_cmd_rx.sv
design/spi_reply_tx.sv
design/ps2_fifo.sv
design/ps2_tx.sv
design/user_io.sv
test/tb_user_io.sv

// File: Makefile
# Verilator build and run of the IO bridge testbench

TOP := tb_user_io

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
